// File: common/rv_fe_pkg.sv
package rv_fe_pkg;

  // Address and data word of the core
  typedef logic [31:0] xlen_t;

  // Next-PC source picked by the arbiter
  typedef enum logic [1:0] {
    PC_SEL_SEQUENTIAL = 2'b00,
    PC_SEL_PREDICTED  = 2'b01,
    PC_SEL_REDIRECT   = 2'b10
  } pc_sel_e;

  // Metadata travelling with each fetch PC
  // redir_pending asks the hazard logic for an extended flush
  typedef struct packed {
    logic  redir_pending;
    logic  pred_taken;
    xlen_t pred_tgt;
  } fetch_meta_t;

  // PC pair handed to the IF stage
  typedef struct packed {
    xlen_t pc;
    xlen_t pc_next;
  } fetch_pc_t;

  // Byte offsets of the APB registers
  localparam logic [11:0] REG_CTRL      = 12'h000;
  localparam logic [11:0] REG_REDIR_CNT = 12'h004;

  // Bit positions inside REG_CTRL
  localparam int CTRL_PRED_EN_BIT = 0;

endpackage

// File: common/rv_pc_sel_if.sv
`timescale 1ns/1ps

interface rv_pc_sel_if;

  // Chosen source for the next PC
  rv_fe_pkg::pc_sel_e sel;

  // Target used when sel is REDIRECT
  rv_fe_pkg::xlen_t redir_tgt;

  // Target used when sel is PREDICTED, from BTB or RAS
  rv_fe_pkg::xlen_t pred_tgt;

  // Set when the prediction came from the BTB
  // The sequential fetch never happened, so no extended flush
  logic early_pred;

  // Arbiter side drives everything combinationally
  modport arbiter (
    output sel,
    output redir_tgt,
    output pred_tgt,
    output early_pred
  );

  // PC stage samples the values on the cycle it advances
  modport stage (
    input sel,
    input redir_tgt,
    input pred_tgt,
    input early_pred
  );

endinterface

// File: rtl/rv_pipe_ctrl.sv
`timescale 1ns/1ps

module rv_pipe_ctrl #(
  parameter int REG = 1
) (
  input  logic clk,
  input  logic rst_n,
  input  logic valid_i,
  input  logic ready_i,
  input  logic stall_i,
  output logic valid_o,
  output logic advance_o
);

  // Boundary moves only when downstream takes it and hazards allow
  assign advance_o = ready_i && !stall_i;

  if (REG != 0) begin : g_reg
    logic valid_q;

    // Valid follows the producer one cycle late
    // Held through back-pressure so a presented PC is never dropped
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        valid_q <= 1'b0;
      end else if (advance_o) begin
        valid_q <= valid_i;
      end
    end

    assign valid_o = valid_q;
  end else begin : g_pass
    // Combinational boundary, valid is whatever the producer says
    assign valid_o = valid_i;
  end

endmodule

// File: rtl/rv_pipe_data.sv
`timescale 1ns/1ps

module rv_pipe_data #(
  parameter int  REG = 1,
  parameter type T   = logic
) (
  input  logic clk,
  input  logic rst_n,
  input  logic advance_i,
  input  T     data_i,
  output T     data_o
);

  if (REG != 0) begin : g_reg
    T data_q;

    // Payload register, captured together with valid
    // Cleared on reset so metadata flags start low
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        data_q <= '0;
      end else if (advance_i) begin
        data_q <= data_i;
      end
    end

    assign data_o = data_q;
  end else begin : g_pass
    // No register at this boundary
    assign data_o = data_i;
  end

endmodule

// File: rv_pc/rv_pc_sel.sv
`timescale 1ns/1ps

module rv_pc_sel (
  input  logic                  pred_en_i,
  input  logic                  redirect_valid_i,
  input  rv_fe_pkg::xlen_t      redirect_tgt_i,
  input  logic                  btb_hit_i,
  input  logic                  btb_taken_i,
  input  rv_fe_pkg::xlen_t      btb_tgt_i,
  input  logic                  btb_is_return_i,
  input  logic                  ras_valid_i,
  input  rv_fe_pkg::xlen_t      ras_tgt_i,
  rv_pc_sel_if.arbiter          sel_o
);

  logic btb_pred;
  logic ras_pred;

  // Early prediction, BTB hit with a taken direction
  assign btb_pred = pred_en_i && btb_hit_i && btb_taken_i;

  // Late prediction, return with a valid RAS entry
  assign ras_pred = pred_en_i && btb_is_return_i && ras_valid_i;

  // Execute redirect always goes straight through
  assign sel_o.redir_tgt = redirect_tgt_i;

  // Predicted target, BTB wins over RAS
  assign sel_o.pred_tgt = btb_pred ? btb_tgt_i : ras_tgt_i;

  // Priority: redirect, then BTB, then RAS, then pc + 4
  always_comb begin
    sel_o.sel        = rv_fe_pkg::PC_SEL_SEQUENTIAL;
    sel_o.early_pred = 1'b0;

    if (redirect_valid_i) begin
      sel_o.sel = rv_fe_pkg::PC_SEL_REDIRECT;
    end else if (btb_pred) begin
      sel_o.sel        = rv_fe_pkg::PC_SEL_PREDICTED;
      sel_o.early_pred = 1'b1;
    end else if (ras_pred) begin
      // RAS resolves late, the sequential fetch is already in flight
      sel_o.sel = rv_fe_pkg::PC_SEL_PREDICTED;
    end
  end

endmodule

// File: rv_pc/rv_stage_pc.sv
`timescale 1ns/1ps

module rv_stage_pc #(
  parameter int               PC_REG   = 1,
  parameter rv_fe_pkg::xlen_t RESET_PC = 32'h0000_0000
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   fetch_ready_i,
  input  logic                   stall_i,
  rv_pc_sel_if.stage             sel_i,
  output rv_fe_pkg::xlen_t       pc_o,
  output logic                   fetch_valid_o,
  output rv_fe_pkg::fetch_pc_t   fetch_pc_o,
  output rv_fe_pkg::fetch_meta_t fetch_meta_o,
  output logic                   advance_o
);

  rv_fe_pkg::xlen_t       pc;
  rv_fe_pkg::xlen_t       pc_next;
  rv_fe_pkg::fetch_pc_t   pc_pair;
  rv_fe_pkg::fetch_meta_t meta;
  logic                   advance;
  logic                   redir_pending;
  logic                   pred_taken;

  // Next-PC mux driven by the arbiter select
  always_comb begin
    case (sel_i.sel)
      rv_fe_pkg::PC_SEL_REDIRECT:  pc_next = sel_i.redir_tgt;
      rv_fe_pkg::PC_SEL_PREDICTED: pc_next = sel_i.pred_tgt;
      default:                     pc_next = pc + 32'd4;
    endcase
  end

  // PC register, moves only when the IF boundary advances
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (advance) begin
      pc <= pc_next;
    end
  end

  // Redirects and late predictions leave a wrong-path fetch behind
  // BTB predictions redirect before the sequential fetch starts
  assign redir_pending = (sel_i.sel == rv_fe_pkg::PC_SEL_REDIRECT) ||
                         (sel_i.sel == rv_fe_pkg::PC_SEL_PREDICTED && !sel_i.early_pred);

  assign pred_taken = (sel_i.sel == rv_fe_pkg::PC_SEL_PREDICTED);

  // Payloads for the PC/IF boundary
  assign pc_pair.pc         = pc;
  assign pc_pair.pc_next    = pc_next;
  assign meta.redir_pending = redir_pending;
  assign meta.pred_taken    = pred_taken;
  assign meta.pred_tgt      = sel_i.pred_tgt;

  // Source stage, always has a PC to offer
  rv_pipe_ctrl #(
    .REG(PC_REG)
  ) u_pipe_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .valid_i  (1'b1),
    .ready_i  (fetch_ready_i),
    .stall_i  (stall_i),
    .valid_o  (fetch_valid_o),
    .advance_o(advance)
  );

  // PC pair to IF
  rv_pipe_data #(
    .REG(PC_REG),
    .T  (rv_fe_pkg::fetch_pc_t)
  ) u_pipe_pc (
    .clk      (clk),
    .rst_n    (rst_n),
    .advance_i(advance),
    .data_i   (pc_pair),
    .data_o   (fetch_pc_o)
  );

  // Prediction metadata, aligned with the PC pair
  rv_pipe_data #(
    .REG(PC_REG),
    .T  (rv_fe_pkg::fetch_meta_t)
  ) u_pipe_meta (
    .clk      (clk),
    .rst_n    (rst_n),
    .advance_i(advance),
    .data_i   (meta),
    .data_o   (fetch_meta_o)
  );

  // Current PC feeds the external BTB lookup
  assign pc_o      = pc;
  assign advance_o = advance;

endmodule

// File: rtl/rv_fe_csr.sv
`timescale 1ns/1ps

module rv_fe_csr (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             psel_i,
  input  logic             penable_i,
  input  logic             pwrite_i,
  input  logic [11:0]      paddr_i,
  input  rv_fe_pkg::xlen_t pwdata_i,
  input  logic             advance_i,
  input  logic             redirect_valid_i,
  output rv_fe_pkg::xlen_t prdata_o,
  output logic             pready_o,
  output logic             pred_en_o
);

  logic             wr_en;
  logic             rd_en;
  logic             pred_en;
  rv_fe_pkg::xlen_t redir_cnt;

  // Zero wait states, access phase completes at once
  assign pready_o = 1'b1;

  // Writes land on the access-phase clock
  assign wr_en = psel_i && penable_i && pwrite_i;
  assign rd_en = psel_i && !pwrite_i;

  // Control register, only the prediction enable lives here
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pred_en <= 1'b0;
    end else if (wr_en && paddr_i == rv_fe_pkg::REG_CTRL) begin
      pred_en <= pwdata_i[rv_fe_pkg::CTRL_PRED_EN_BIT];
    end
  end

  // Counts redirects the PC actually took
  // Read-only, APB writes to this offset fall through
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      redir_cnt <= '0;
    end else if (advance_i && redirect_valid_i) begin
      redir_cnt <= redir_cnt + 32'd1;
    end
  end

  // Read mux, unmapped offsets return zero
  always_comb begin
    prdata_o = '0;
    if (rd_en) begin
      case (paddr_i)
        rv_fe_pkg::REG_CTRL: begin
          prdata_o[rv_fe_pkg::CTRL_PRED_EN_BIT] = pred_en;
        end
        rv_fe_pkg::REG_REDIR_CNT: begin
          prdata_o = redir_cnt;
        end
        default: begin
          prdata_o = '0;
        end
      endcase
    end
  end

  assign pred_en_o = pred_en;

endmodule

// File: rtl/rv_fe_top.sv
`timescale 1ns/1ps

module rv_fe_top #(
  parameter int               PC_REG   = 1,
  parameter rv_fe_pkg::xlen_t RESET_PC = 32'h0000_0000
) (
  input  logic             clk,
  input  logic             rst_n,
  // APB slave
  input  logic             psel_i,
  input  logic             penable_i,
  input  logic             pwrite_i,
  input  logic [11:0]      paddr_i,
  input  rv_fe_pkg::xlen_t pwdata_i,
  output rv_fe_pkg::xlen_t prdata_o,
  output logic             pready_o,
  // IF handshake and hazard stall
  input  logic             fetch_ready_i,
  input  logic             stall_i,
  // Execute redirect
  input  logic             redirect_valid_i,
  input  rv_fe_pkg::xlen_t redirect_tgt_i,
  // BTB and RAS lookup results
  input  logic             btb_hit_i,
  input  logic             btb_taken_i,
  input  rv_fe_pkg::xlen_t btb_tgt_i,
  input  logic             btb_is_return_i,
  input  logic             ras_valid_i,
  input  rv_fe_pkg::xlen_t ras_tgt_i,
  // Fetch side
  output rv_fe_pkg::xlen_t pc_o,
  output logic             fetch_valid_o,
  output rv_fe_pkg::xlen_t fetch_pc_o,
  output rv_fe_pkg::xlen_t fetch_pc_next_o,
  output logic             redir_pending_o,
  output logic             pred_taken_o,
  output rv_fe_pkg::xlen_t pred_tgt_o
);

  logic                   pred_en;
  logic                   advance;
  rv_fe_pkg::fetch_pc_t   fetch_pc;
  rv_fe_pkg::fetch_meta_t fetch_meta;

  rv_pc_sel_if u_sel_if ();

  // Register block steering the arbiter
  rv_fe_csr u_csr (
    .clk             (clk),
    .rst_n           (rst_n),
    .psel_i          (psel_i),
    .penable_i       (penable_i),
    .pwrite_i        (pwrite_i),
    .paddr_i         (paddr_i),
    .pwdata_i        (pwdata_i),
    .advance_i       (advance),
    .redirect_valid_i(redirect_valid_i),
    .prdata_o        (prdata_o),
    .pready_o        (pready_o),
    .pred_en_o       (pred_en)
  );

  rv_pc_sel u_pc_sel (
    .pred_en_i       (pred_en),
    .redirect_valid_i(redirect_valid_i),
    .redirect_tgt_i  (redirect_tgt_i),
    .btb_hit_i       (btb_hit_i),
    .btb_taken_i     (btb_taken_i),
    .btb_tgt_i       (btb_tgt_i),
    .btb_is_return_i (btb_is_return_i),
    .ras_valid_i     (ras_valid_i),
    .ras_tgt_i       (ras_tgt_i),
    .sel_o           (u_sel_if.arbiter)
  );

  rv_stage_pc #(
    .PC_REG  (PC_REG),
    .RESET_PC(RESET_PC)
  ) u_stage_pc (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_ready_i(fetch_ready_i),
    .stall_i      (stall_i),
    .sel_i        (u_sel_if.stage),
    .pc_o         (pc_o),
    .fetch_valid_o(fetch_valid_o),
    .fetch_pc_o   (fetch_pc),
    .fetch_meta_o (fetch_meta),
    .advance_o    (advance)
  );

  // Flatten the boundary payloads onto plain ports
  assign fetch_pc_o      = fetch_pc.pc;
  assign fetch_pc_next_o = fetch_pc.pc_next;
  assign redir_pending_o = fetch_meta.redir_pending;
  assign pred_taken_o    = fetch_meta.pred_taken;
  assign pred_tgt_o      = fetch_meta.pred_tgt;

endmodule

// File: test/rv_fe_props.sv
`timescale 1ns/1ps

module rv_fe_props (
  input logic             clk,
  input logic             rst_n,
  input logic             advance_i,
  input logic             redirect_valid_i,
  input logic             fetch_valid_i,
  input rv_fe_pkg::xlen_t fetch_pc_i,
  input rv_fe_pkg::xlen_t fetch_pc_next_i,
  input logic             redir_pending_i,
  input logic             pred_taken_i,
  input rv_fe_pkg::xlen_t pred_tgt_i
);

  // Nothing is presented in the first cycle out of reset
  a_valid_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !fetch_valid_i)
    else $error("fetch valid high in the first cycle after reset");

  // Back-pressure freezes the whole PC/IF boundary
  a_hold_on_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
    !advance_i |=> $stable(fetch_valid_i) && $stable(fetch_pc_i) &&
                   $stable(fetch_pc_next_i) && $stable(redir_pending_i) &&
                   $stable(pred_taken_i) && $stable(pred_tgt_i))
    else $error("fetch outputs moved while the boundary was held");

  // Pending flush comes from a late prediction or a taken redirect
  a_pending_cause: assert property (@(posedge clk) disable iff (!rst_n)
    advance_i |=> (!redir_pending_i || pred_taken_i || $past(redirect_valid_i)))
    else $error("redirect pending without a prediction or redirect");

endmodule

// File: test/rv_fe_tb.sv
`timescale 1ns/1ps

module rv_fe_tb;

  localparam int N_ROWS = 15;
  // At most four cycles per row, the rest covers reset and APB traffic
  localparam int TIMEOUT = 4 * N_ROWS + 100;
  localparam rv_fe_pkg::xlen_t RESET_PC = 32'h0000_0100;

  // One row per accepted advance
  typedef struct packed {
    logic [127:0]     name;
    logic             pred_en;
    logic             redir_v;
    rv_fe_pkg::xlen_t redir_tgt;
    logic             btb_hit;
    logic             btb_taken;
    rv_fe_pkg::xlen_t btb_tgt;
    logic             is_ret;
    logic             ras_v;
    rv_fe_pkg::xlen_t ras_tgt;
    rv_fe_pkg::xlen_t exp_next;
    logic             exp_pend;
  } row_t;

  // name, pred_en, redirect v/tgt, btb hit/taken/tgt, return, ras v/tgt, pc_next, pending
  localparam row_t ROWS [N_ROWS] = '{
    '{"seq0",           1'b0, 1'b0, 32'h0,    1'b0, 1'b0, 32'h0,    1'b0, 1'b0, 32'h0,
      32'h104,  1'b0},
    '{"seq1",           1'b0, 1'b0, 32'h0,    1'b0, 1'b0, 32'h0,    1'b0, 1'b0, 32'h0,
      32'h108,  1'b0},
    '{"btb_off",        1'b0, 1'b0, 32'h0,    1'b1, 1'b1, 32'h2000, 1'b0, 1'b0, 32'h0,
      32'h10c,  1'b0},
    '{"ras_off",        1'b0, 1'b0, 32'h0,    1'b0, 1'b0, 32'h0,    1'b1, 1'b1, 32'h3000,
      32'h110,  1'b0},
    '{"btb_on",         1'b1, 1'b0, 32'h0,    1'b1, 1'b1, 32'h2000, 1'b0, 1'b0, 32'h0,
      32'h2000, 1'b0},
    '{"seq_after_btb",  1'b1, 1'b0, 32'h0,    1'b0, 1'b0, 32'h0,    1'b0, 1'b0, 32'h0,
      32'h2004, 1'b0},
    '{"btb_not_taken",  1'b1, 1'b0, 32'h0,    1'b1, 1'b0, 32'h5000, 1'b0, 1'b0, 32'h0,
      32'h2008, 1'b0},
    '{"ras_on",         1'b1, 1'b0, 32'h0,    1'b0, 1'b0, 32'h0,    1'b1, 1'b1, 32'h3000,
      32'h3000, 1'b1},
    '{"ras_empty",      1'b1, 1'b0, 32'h0,    1'b0, 1'b0, 32'h0,    1'b1, 1'b0, 32'h6000,
      32'h3004, 1'b0},
    '{"redirect",       1'b1, 1'b1, 32'h4000, 1'b0, 1'b0, 32'h0,    1'b0, 1'b0, 32'h0,
      32'h4000, 1'b1},
    '{"redir_over_btb", 1'b1, 1'b1, 32'h4800, 1'b1, 1'b1, 32'h7000, 1'b0, 1'b0, 32'h0,
      32'h4800, 1'b1},
    '{"btb_over_ras",   1'b1, 1'b0, 32'h0,    1'b1, 1'b1, 32'h8000, 1'b1, 1'b1, 32'h9000,
      32'h8000, 1'b0},
    '{"seq_after_pred", 1'b1, 1'b0, 32'h0,    1'b0, 1'b0, 32'h0,    1'b0, 1'b0, 32'h0,
      32'h8004, 1'b0},
    '{"redir_pred_off", 1'b0, 1'b1, 32'h500,  1'b1, 1'b1, 32'ha000, 1'b0, 1'b0, 32'h0,
      32'h500,  1'b1},
    '{"seq_last",       1'b0, 1'b0, 32'h0,    1'b0, 1'b0, 32'h0,    1'b0, 1'b0, 32'h0,
      32'h504,  1'b0}
  };

  logic             clk;
  logic             rst_n;
  logic             psel_i;
  logic             penable_i;
  logic             pwrite_i;
  logic [11:0]      paddr_i;
  rv_fe_pkg::xlen_t pwdata_i;
  rv_fe_pkg::xlen_t prdata_o;
  logic             pready_o;
  logic             fetch_ready_i;
  logic             stall_i;
  logic             redirect_valid_i;
  rv_fe_pkg::xlen_t redirect_tgt_i;
  logic             btb_hit_i;
  logic             btb_taken_i;
  rv_fe_pkg::xlen_t btb_tgt_i;
  logic             btb_is_return_i;
  logic             ras_valid_i;
  rv_fe_pkg::xlen_t ras_tgt_i;
  rv_fe_pkg::xlen_t pc_o;
  logic             fetch_valid_o;
  rv_fe_pkg::xlen_t fetch_pc_o;
  rv_fe_pkg::xlen_t fetch_pc_next_o;
  logic             redir_pending_o;
  logic             pred_taken_o;
  rv_fe_pkg::xlen_t pred_tgt_o;
  int               cycles = 0;

  rv_fe_top #(
    .PC_REG  (1),
    .RESET_PC(RESET_PC)
  ) u_dut (.*);

  // Handshake and metadata checks on the PC/IF boundary
  bind rv_fe_top rv_fe_props u_props (
    .clk             (clk),
    .rst_n           (rst_n),
    .advance_i       (advance),
    .redirect_valid_i(redirect_valid_i),
    .fetch_valid_i   (fetch_valid_o),
    .fetch_pc_i      (fetch_pc_o),
    .fetch_pc_next_i (fetch_pc_next_o),
    .redir_pending_i (redir_pending_o),
    .pred_taken_i    (pred_taken_o),
    .pred_tgt_i      (pred_tgt_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_xlen(input string name, input rv_fe_pkg::xlen_t exp,
                            input rv_fe_pkg::xlen_t act);
    if (act !== exp) begin
      fail_stop($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      fail_stop($sformatf("FAIL %s expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic check_meta(input string name, input rv_fe_pkg::fetch_meta_t exp,
                            input rv_fe_pkg::fetch_meta_t act);
    if (act !== exp) begin
      fail_stop($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    end
  endtask

  // Zero-wait APB write, setup then access phase
  task automatic apb_write(input logic [11:0] addr, input rv_fe_pkg::xlen_t data);
    @(negedge clk);
    psel_i    = 1'b1;
    pwrite_i  = 1'b1;
    paddr_i   = addr;
    pwdata_i  = data;
    @(negedge clk);
    penable_i = 1'b1;
    @(negedge clk);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  // Read data sampled mid low phase of the access cycle
  task automatic apb_read(input logic [11:0] addr, output rv_fe_pkg::xlen_t data);
    @(negedge clk);
    psel_i    = 1'b1;
    pwrite_i  = 1'b0;
    paddr_i   = addr;
    @(negedge clk);
    penable_i = 1'b1;
    #2;
    check_bit("apb pready", 1'b1, pready_o);
    data = prdata_o;
    @(negedge clk);
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      fail_stop("Timeout, the stimulus table did not finish in time");
    end
  end

  initial begin
    rv_fe_pkg::xlen_t model_pc;
    rv_fe_pkg::xlen_t rdata;
    rv_fe_pkg::xlen_t redirs;
    logic             cur_en;
    logic             pred;
    logic             go;
    int               tries;
    string            nm;
    void'($urandom(87550));
    rst_n            = 1'b0;
    psel_i           = 1'b0;
    penable_i        = 1'b0;
    pwrite_i         = 1'b0;
    paddr_i          = '0;
    pwdata_i         = '0;
    fetch_ready_i    = 1'b0;
    stall_i          = 1'b0;
    redirect_valid_i = 1'b0;
    redirect_tgt_i   = '0;
    btb_hit_i        = 1'b0;
    btb_taken_i      = 1'b0;
    btb_tgt_i        = '0;
    btb_is_return_i  = 1'b0;
    ras_valid_i      = 1'b0;
    ras_tgt_i        = '0;
    model_pc         = RESET_PC;
    redirs           = '0;
    cur_en           = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    // Boundary empty and flags clear out of reset
    check_bit("reset fetch_valid", 1'b0, fetch_valid_o);
    check_meta("reset meta", '0, {redir_pending_o, pred_taken_o, pred_tgt_o});
    check_xlen("reset pc_o", RESET_PC, pc_o);
    for (int i = 0; i < N_ROWS; i++) begin
      nm = $sformatf("%0s", ROWS[i].name);
      if (ROWS[i].pred_en != cur_en) begin
        apb_write(rv_fe_pkg::REG_CTRL, {31'd0, ROWS[i].pred_en});
        apb_read(rv_fe_pkg::REG_CTRL, rdata);
        check_xlen({nm, " ctrl readback"}, {31'd0, ROWS[i].pred_en}, rdata);
        cur_en = ROWS[i].pred_en;
      end
      check_xlen({nm, " pc_o"}, model_pc, pc_o);
      redirect_valid_i = ROWS[i].redir_v;
      redirect_tgt_i   = ROWS[i].redir_tgt;
      btb_hit_i        = ROWS[i].btb_hit;
      btb_taken_i      = ROWS[i].btb_taken;
      btb_tgt_i        = ROWS[i].btb_tgt;
      btb_is_return_i  = ROWS[i].is_ret;
      ras_valid_i      = ROWS[i].ras_v;
      ras_tgt_i        = ROWS[i].ras_tgt;
      // Random back-pressure, forced through on the fourth try
      tries = 0;
      go    = 1'b0;
      while (!go) begin
        if (tries == 3) begin
          fetch_ready_i = 1'b1;
          stall_i       = 1'b0;
        end else begin
          fetch_ready_i = ($urandom % 4) != 0;
          stall_i       = ($urandom % 4) == 0;
        end
        go = fetch_ready_i && !stall_i;
        tries++;
        @(negedge clk);
      end
      // Prediction only when enabled and no redirect wins
      pred = !ROWS[i].redir_v && ROWS[i].pred_en &&
             ((ROWS[i].btb_hit && ROWS[i].btb_taken) || (ROWS[i].is_ret && ROWS[i].ras_v));
      check_bit({nm, " fetch_valid"}, 1'b1, fetch_valid_o);
      check_xlen({nm, " fetch_pc"}, model_pc, fetch_pc_o);
      check_xlen({nm, " fetch_pc_next"}, ROWS[i].exp_next, fetch_pc_next_o);
      check_bit({nm, " redir_pending"}, ROWS[i].exp_pend, redir_pending_o);
      check_bit({nm, " pred_taken"}, pred, pred_taken_o);
      if (pred) begin
        check_xlen({nm, " pred_tgt"}, ROWS[i].exp_next, pred_tgt_o);
      end
      if (ROWS[i].redir_v) begin
        redirs = redirs + 32'd1;
      end
      model_pc = ROWS[i].exp_next;
      // Hold the PC while APB traffic runs between rows
      fetch_ready_i = 1'b0;
    end
    redirect_valid_i = 1'b0;
    // Counter holds accepted redirects and ignores writes
    apb_read(rv_fe_pkg::REG_REDIR_CNT, rdata);
    check_xlen("redirect count", redirs, rdata);
    apb_write(rv_fe_pkg::REG_REDIR_CNT, 32'hffff_ffff);
    apb_read(rv_fe_pkg::REG_REDIR_CNT, rdata);
    check_xlen("redirect count after write", redirs, rdata);
    $display("All tests passed");
    $finish;
  end

endmodule

// File: verilog.f
common/rv_fe_pkg.sv
common/rv_pc_sel_if.sv
rtl/rv_pipe_ctrl.sv
rtl/rv_pipe_data.sv
rv_pc/rv_pc_sel.sv
rv_pc/rv_stage_pc.sv
rtl/rv_fe_csr.sv
rtl/rv_fe_top.sv
test/rv_fe_props.sv
test/rv_fe_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the fetch front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module rv_fe_tb -f verilog.f

# A $fatal in the testbench or a failed assertion gives a non-zero exit
./obj_dir/Vrv_fe_tb
